// File: hw/xbar_config.svh
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// Message field widths
`define XBAR_PADDR_WIDTH 32
`define XBAR_DATA_WIDTH  64
`define XBAR_SRC_WIDTH   2

// Instruction fetch, data access and incoming I/O
`define XBAR_NUM_REQ 3

// Everything from here up is DRAM
`define XBAR_DRAM_BASE 32'h8000_0000

// Device field of a local address is 4 bits starting here
`define XBAR_DEV_LSB 20

// Local device routed to the outgoing I/O port
`define XBAR_IO_DEV 4'h1

// Local devices other than I/O end at the loopback

`endif

// File: hw/xbar_pkg.sv
`default_nettype none

`include "xbar_config.svh"

package xbar_pkg;

  // Physical address
  typedef logic [`XBAR_PADDR_WIDTH-1:0] paddr_t;

  // One data word of a memory message
  typedef logic [`XBAR_DATA_WIDTH-1:0] word_t;

  // Requester that issued the message
  typedef logic [`XBAR_SRC_WIDTH-1:0] src_id_t;

  // Device field of a local address
  typedef logic [3:0] dev_id_t;

  // Memory opcode
  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

endpackage

`default_nettype wire

// File: hw/two_entry_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module two_entry_fifo
  (  input  logic                clk_i
   , input  logic                arst_n_i

   , input  xbar_pkg::mem_op_e   op_i
   , input  xbar_pkg::paddr_t    addr_i
   , input  xbar_pkg::src_id_t   src_i
   , input  xbar_pkg::word_t     data_i
   , input  logic                v_i
   , output logic                ready_o

   , output xbar_pkg::mem_op_e   op_o
   , output xbar_pkg::paddr_t    addr_o
   , output xbar_pkg::src_id_t   src_o
   , output xbar_pkg::word_t     data_o
   , output logic                v_o
   , input  logic                yumi_i
   );

  xbar_pkg::mem_op_e op_mem   [2];
  xbar_pkg::paddr_t  addr_mem [2];
  xbar_pkg::src_id_t src_mem  [2];
  xbar_pkg::word_t   data_mem [2];

  logic rptr_q, wptr_q, full_q;
  logic enq, deq;

  assign enq = v_i & ~full_q;
  assign deq = yumi_i;

  assign ready_o = ~full_q;
  assign v_o     = full_q | (rptr_q != wptr_q);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rptr_q <= 1'b0;
      wptr_q <= 1'b0;
      full_q <= 1'b0;
    end
    else
    begin
      if (enq) wptr_q <= ~wptr_q;
      if (deq) rptr_q <= ~rptr_q;
      // Full only when a write lands on the slot just ahead of the read pointer
      if (enq & ~deq) full_q <= (~wptr_q == rptr_q);
      else if (deq & ~enq) full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      op_mem[wptr_q]   <= op_i;
      addr_mem[wptr_q] <= addr_i;
      src_mem[wptr_q]  <= src_i;
      data_mem[wptr_q] <= data_i;
    end
  end

  assign op_o   = op_mem[rptr_q];
  assign addr_o = addr_mem[rptr_q];
  assign src_o  = src_mem[rptr_q];
  assign data_o = data_mem[rptr_q];

endmodule

`default_nettype wire

// File: hw/loopback_responder.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_responder
  (  input  logic                clk_i
   , input  logic                arst_n_i

   , input  xbar_pkg::mem_op_e   cmd_op_i
   , input  xbar_pkg::paddr_t    cmd_addr_i
   , input  xbar_pkg::src_id_t   cmd_src_i
   , input  logic                cmd_v_i
   , output logic                cmd_ready_o

   , output xbar_pkg::mem_op_e   resp_op_o
   , output xbar_pkg::paddr_t    resp_addr_o
   , output xbar_pkg::src_id_t   resp_src_o
   , output xbar_pkg::word_t     resp_data_o
   , output logic                resp_v_o
   , input  logic                resp_yumi_i
   );

  logic resp_v_q;

  // One pending response at a time
  assign cmd_ready_o = ~resp_v_q;
  assign resp_v_o    = resp_v_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (cmd_v_i & cmd_ready_o)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i & cmd_ready_o)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
      resp_src_o  <= cmd_src_i;
    end
  end

  // Reads of unmapped space return zero, writes are dropped
  assign resp_data_o = '0;

endmodule

`default_nettype wire

// File: hw/cmd_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module cmd_router
  (  // Heads of the command FIFOs
     input  xbar_pkg::mem_op_e [`XBAR_NUM_REQ-1:0]  fifo_op_i
   , input  xbar_pkg::paddr_t  [`XBAR_NUM_REQ-1:0]  fifo_addr_i
   , input  xbar_pkg::src_id_t [`XBAR_NUM_REQ-1:0]  fifo_src_i
   , input  xbar_pkg::word_t   [`XBAR_NUM_REQ-1:0]  fifo_data_i
   , input  logic              [`XBAR_NUM_REQ-1:0]  fifo_v_i
   , output logic              [`XBAR_NUM_REQ-1:0]  fifo_yumi_o

   // Shared command bus to all destinations
   , output xbar_pkg::mem_op_e                      cmd_op_o
   , output xbar_pkg::paddr_t                       cmd_addr_o
   , output xbar_pkg::src_id_t                      cmd_src_o
   , output xbar_pkg::word_t                        cmd_data_o
   , output logic                                   dram_cmd_v_o
   , output logic                                   io_cmd_v_o
   , output logic                                   lb_cmd_v_o

   , input  logic                                   dram_ready_i
   , input  logic                                   io_ready_i
   , input  logic                                   lb_ready_i
   );

  xbar_pkg::src_id_t sel;
  xbar_pkg::dev_id_t dev;
  logic              all_ready;
  logic              grant_v;
  logic              is_local;
  logic              is_io;

  // A stalled destination blocks every grant, even to the others
  assign all_ready = dram_ready_i & io_ready_i & lb_ready_i;
  assign grant_v   = all_ready & (|fifo_v_i);

  // Highest index wins, so incoming I/O goes before data and fetch
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < `XBAR_NUM_REQ; i++)
    begin
      if (fifo_v_i[i])
      begin
        sel = xbar_pkg::src_id_t'(i);
      end
    end
  end

  always_comb
  begin
    fifo_yumi_o = '0;
    if (grant_v)
    begin
      fifo_yumi_o[sel] = 1'b1;
    end
  end

  assign cmd_op_o   = fifo_op_i[sel];
  assign cmd_addr_o = fifo_addr_i[sel];
  assign cmd_src_o  = fifo_src_i[sel];
  assign cmd_data_o = fifo_data_i[sel];

  // Local memory map
  assign is_local = (cmd_addr_o < xbar_pkg::paddr_t'(`XBAR_DRAM_BASE));
  assign dev      = cmd_addr_o[`XBAR_DEV_LSB +: $bits(xbar_pkg::dev_id_t)];
  assign is_io    = is_local & (dev == xbar_pkg::dev_id_t'(`XBAR_IO_DEV));

  assign dram_cmd_v_o = grant_v & ~is_local;
  assign io_cmd_v_o   = grant_v & is_io;
  // Unmapped local devices are answered by the loopback
  assign lb_cmd_v_o   = grant_v & is_local & ~is_io;

endmodule

`default_nettype wire

// File: hw/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module resp_router
  (  // Index 0 is the loopback, 1 is DRAM, 2 is I/O
     input  xbar_pkg::mem_op_e [2:0]                src_op_i
   , input  xbar_pkg::paddr_t  [2:0]                src_addr_i
   , input  xbar_pkg::src_id_t [2:0]                src_src_i
   , input  xbar_pkg::word_t   [2:0]                src_data_i
   , input  logic              [2:0]                src_v_i
   , output logic              [2:0]                src_yumi_o

   // Shared response bus to the response FIFOs
   , output xbar_pkg::mem_op_e                      resp_op_o
   , output xbar_pkg::paddr_t                       resp_addr_o
   , output xbar_pkg::src_id_t                      resp_src_o
   , output xbar_pkg::word_t                        resp_data_o
   , output logic              [`XBAR_NUM_REQ-1:0]  resp_v_o
   , input  logic              [`XBAR_NUM_REQ-1:0]  fifo_ready_i
   );

  localparam int num_src_lp = 3;

  logic [1:0] sel;
  logic       all_ready;
  logic       grant_v;

  // Wait for room in every FIFO so the target need not be known first
  assign all_ready = &fifo_ready_i;
  assign grant_v   = all_ready & (|src_v_i);

  // Lowest index wins
  always_comb
  begin
    sel = '0;
    for (int i = num_src_lp - 1; i >= 0; i--)
    begin
      if (src_v_i[i])
      begin
        sel = 2'(i);
      end
    end
  end

  always_comb
  begin
    src_yumi_o = '0;
    if (grant_v)
    begin
      src_yumi_o[sel] = 1'b1;
    end
  end

  assign resp_op_o   = src_op_i[sel];
  assign resp_addr_o = src_addr_i[sel];
  assign resp_src_o  = src_src_i[sel];
  assign resp_data_o = src_data_i[sel];

  // A src with no matching requester is consumed and dropped here
  for (genvar r = 0; r < `XBAR_NUM_REQ; r++)
  begin : g_steer
    assign resp_v_o[r] = grant_v & (resp_src_o == xbar_pkg::src_id_t'(r));
  end

endmodule

`default_nettype wire

// File: hw/unicore_mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module unicore_mem_xbar
  (  input  logic                                   clk_i
   , input  logic                                   arst_n_i

   // Requester channels
   , input  xbar_pkg::mem_op_e [`XBAR_NUM_REQ-1:0]  req_cmd_op_i
   , input  xbar_pkg::paddr_t  [`XBAR_NUM_REQ-1:0]  req_cmd_addr_i
   , input  xbar_pkg::src_id_t [`XBAR_NUM_REQ-1:0]  req_cmd_src_i
   , input  xbar_pkg::word_t   [`XBAR_NUM_REQ-1:0]  req_cmd_data_i
   , input  logic              [`XBAR_NUM_REQ-1:0]  req_cmd_v_i
   , output logic              [`XBAR_NUM_REQ-1:0]  req_cmd_ready_o

   , output xbar_pkg::mem_op_e [`XBAR_NUM_REQ-1:0]  req_resp_op_o
   , output xbar_pkg::paddr_t  [`XBAR_NUM_REQ-1:0]  req_resp_addr_o
   , output xbar_pkg::src_id_t [`XBAR_NUM_REQ-1:0]  req_resp_src_o
   , output xbar_pkg::word_t   [`XBAR_NUM_REQ-1:0]  req_resp_data_o
   , output logic              [`XBAR_NUM_REQ-1:0]  req_resp_v_o
   , input  logic              [`XBAR_NUM_REQ-1:0]  req_resp_yumi_i

   // DRAM
   , output xbar_pkg::mem_op_e                      dram_cmd_op_o
   , output xbar_pkg::paddr_t                       dram_cmd_addr_o
   , output xbar_pkg::src_id_t                      dram_cmd_src_o
   , output xbar_pkg::word_t                        dram_cmd_data_o
   , output logic                                   dram_cmd_v_o
   , input  logic                                   dram_cmd_ready_i

   , input  xbar_pkg::mem_op_e                      dram_resp_op_i
   , input  xbar_pkg::paddr_t                       dram_resp_addr_i
   , input  xbar_pkg::src_id_t                      dram_resp_src_i
   , input  xbar_pkg::word_t                        dram_resp_data_i
   , input  logic                                   dram_resp_v_i
   , output logic                                   dram_resp_yumi_o

   // Outgoing I/O
   , output xbar_pkg::mem_op_e                      io_cmd_op_o
   , output xbar_pkg::paddr_t                       io_cmd_addr_o
   , output xbar_pkg::src_id_t                      io_cmd_src_o
   , output xbar_pkg::word_t                        io_cmd_data_o
   , output logic                                   io_cmd_v_o
   , input  logic                                   io_cmd_ready_i

   , input  xbar_pkg::mem_op_e                      io_resp_op_i
   , input  xbar_pkg::paddr_t                       io_resp_addr_i
   , input  xbar_pkg::src_id_t                      io_resp_src_i
   , input  xbar_pkg::word_t                        io_resp_data_i
   , input  logic                                   io_resp_v_i
   , output logic                                   io_resp_yumi_o
   );

  localparam int num_dest_lp = 3;

  xbar_pkg::mem_op_e [`XBAR_NUM_REQ-1:0] cf_op;
  xbar_pkg::paddr_t  [`XBAR_NUM_REQ-1:0] cf_addr;
  xbar_pkg::src_id_t [`XBAR_NUM_REQ-1:0] cf_src;
  xbar_pkg::word_t   [`XBAR_NUM_REQ-1:0] cf_data;
  logic              [`XBAR_NUM_REQ-1:0] cf_v, cf_yumi;

  xbar_pkg::mem_op_e cmd_op;
  xbar_pkg::paddr_t  cmd_addr;
  xbar_pkg::src_id_t cmd_src;
  xbar_pkg::word_t   cmd_data;
  logic              lb_cmd_v, lb_cmd_ready;

  xbar_pkg::mem_op_e lb_resp_op;
  xbar_pkg::paddr_t  lb_resp_addr;
  xbar_pkg::src_id_t lb_resp_src;
  xbar_pkg::word_t   lb_resp_data;
  logic              lb_resp_v;

  xbar_pkg::mem_op_e [num_dest_lp-1:0]   rr_op;
  xbar_pkg::paddr_t  [num_dest_lp-1:0]   rr_addr;
  xbar_pkg::src_id_t [num_dest_lp-1:0]   rr_src;
  xbar_pkg::word_t   [num_dest_lp-1:0]   rr_data;
  logic              [num_dest_lp-1:0]   rr_v, rr_yumi;

  xbar_pkg::mem_op_e                     resp_op;
  xbar_pkg::paddr_t                      resp_addr;
  xbar_pkg::src_id_t                     resp_src;
  xbar_pkg::word_t                       resp_data;
  logic              [`XBAR_NUM_REQ-1:0] resp_v, resp_ready;

  for (genvar r = 0; r < `XBAR_NUM_REQ; r++)
  begin : g_fifo
    two_entry_fifo cmd_fifo
      (.clk_i(clk_i), .arst_n_i(arst_n_i)
       ,.op_i(req_cmd_op_i[r]), .addr_i(req_cmd_addr_i[r])
       ,.src_i(req_cmd_src_i[r]), .data_i(req_cmd_data_i[r])
       ,.v_i(req_cmd_v_i[r]), .ready_o(req_cmd_ready_o[r])
       ,.op_o(cf_op[r]), .addr_o(cf_addr[r]), .src_o(cf_src[r]), .data_o(cf_data[r])
       ,.v_o(cf_v[r]), .yumi_i(cf_yumi[r])
       );

    two_entry_fifo resp_fifo
      (.clk_i(clk_i), .arst_n_i(arst_n_i)
       ,.op_i(resp_op), .addr_i(resp_addr), .src_i(resp_src), .data_i(resp_data)
       ,.v_i(resp_v[r]), .ready_o(resp_ready[r])
       ,.op_o(req_resp_op_o[r]), .addr_o(req_resp_addr_o[r])
       ,.src_o(req_resp_src_o[r]), .data_o(req_resp_data_o[r])
       ,.v_o(req_resp_v_o[r]), .yumi_i(req_resp_yumi_i[r])
       );
  end

  cmd_router cmd_rtr
    (.fifo_op_i(cf_op), .fifo_addr_i(cf_addr), .fifo_src_i(cf_src), .fifo_data_i(cf_data)
     ,.fifo_v_i(cf_v), .fifo_yumi_o(cf_yumi)
     ,.cmd_op_o(cmd_op), .cmd_addr_o(cmd_addr), .cmd_src_o(cmd_src), .cmd_data_o(cmd_data)
     ,.dram_cmd_v_o(dram_cmd_v_o), .io_cmd_v_o(io_cmd_v_o), .lb_cmd_v_o(lb_cmd_v)
     ,.dram_ready_i(dram_cmd_ready_i), .io_ready_i(io_cmd_ready_i), .lb_ready_i(lb_cmd_ready)
     );

  // Shared command bus fans out to both outside ports
  assign dram_cmd_op_o   = cmd_op;
  assign dram_cmd_addr_o = cmd_addr;
  assign dram_cmd_src_o  = cmd_src;
  assign dram_cmd_data_o = cmd_data;
  assign io_cmd_op_o     = cmd_op;
  assign io_cmd_addr_o   = cmd_addr;
  assign io_cmd_src_o    = cmd_src;
  assign io_cmd_data_o   = cmd_data;

  loopback_responder loopback
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
     ,.cmd_op_i(cmd_op), .cmd_addr_i(cmd_addr), .cmd_src_i(cmd_src)
     ,.cmd_v_i(lb_cmd_v), .cmd_ready_o(lb_cmd_ready)
     ,.resp_op_o(lb_resp_op), .resp_addr_o(lb_resp_addr), .resp_src_o(lb_resp_src)
     ,.resp_data_o(lb_resp_data), .resp_v_o(lb_resp_v), .resp_yumi_i(rr_yumi[0])
     );

  // Response sources in priority order
  assign rr_op   = {io_resp_op_i,   dram_resp_op_i,   lb_resp_op};
  assign rr_addr = {io_resp_addr_i, dram_resp_addr_i, lb_resp_addr};
  assign rr_src  = {io_resp_src_i,  dram_resp_src_i,  lb_resp_src};
  assign rr_data = {io_resp_data_i, dram_resp_data_i, lb_resp_data};
  assign rr_v    = {io_resp_v_i,    dram_resp_v_i,    lb_resp_v};

  assign dram_resp_yumi_o = rr_yumi[1];
  assign io_resp_yumi_o   = rr_yumi[2];

  resp_router resp_rtr
    (.src_op_i(rr_op), .src_addr_i(rr_addr), .src_src_i(rr_src), .src_data_i(rr_data)
     ,.src_v_i(rr_v), .src_yumi_o(rr_yumi)
     ,.resp_op_o(resp_op), .resp_addr_o(resp_addr), .resp_src_o(resp_src)
     ,.resp_data_o(resp_data), .resp_v_o(resp_v), .fifo_ready_i(resp_ready)
     );

endmodule

`default_nettype wire

// File: bench/unicore_mem_xbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module unicore_mem_xbar_tb;

  localparam int num_req_lp  = `XBAR_NUM_REQ;
  localparam int reqs_per_lp = 200;
  localparam int total_lp    = num_req_lp * reqs_per_lp;
  localparam int timeout_lp  = total_lp * 40;

  // Destination picked by the requester, also the model index for DRAM and I/O
  localparam int kind_dram_lp = 0;
  localparam int kind_io_lp   = 1;
  localparam int kind_lb_lp   = 2;

  logic clk_i    = 1'b0;
  logic arst_n_i = 1'b0;

  xbar_pkg::mem_op_e [num_req_lp-1:0] req_cmd_op = '{default: xbar_pkg::e_mem_rd};
  xbar_pkg::paddr_t  [num_req_lp-1:0] req_cmd_addr = '0;
  xbar_pkg::src_id_t [num_req_lp-1:0] req_cmd_src = '0;
  xbar_pkg::word_t   [num_req_lp-1:0] req_cmd_data = '0;
  logic              [num_req_lp-1:0] req_cmd_v = '0;
  logic              [num_req_lp-1:0] req_cmd_ready;
  xbar_pkg::mem_op_e [num_req_lp-1:0] req_resp_op;
  xbar_pkg::paddr_t  [num_req_lp-1:0] req_resp_addr;
  xbar_pkg::src_id_t [num_req_lp-1:0] req_resp_src;
  xbar_pkg::word_t   [num_req_lp-1:0] req_resp_data;
  logic              [num_req_lp-1:0] req_resp_v;
  logic              [num_req_lp-1:0] resp_yumi = '0;

  xbar_pkg::mem_op_e dram_cmd_op, io_cmd_op;
  xbar_pkg::paddr_t  dram_cmd_addr, io_cmd_addr;
  xbar_pkg::src_id_t dram_cmd_src, io_cmd_src;
  xbar_pkg::word_t   dram_cmd_data, io_cmd_data;
  logic              dram_cmd_v, io_cmd_v, dram_resp_yumi, io_resp_yumi;

  // Outside responder models, index 0 is DRAM and 1 is I/O
  xbar_pkg::mem_op_e [1:0] m_op = '{default: xbar_pkg::e_mem_rd};
  xbar_pkg::paddr_t  [1:0] m_addr = '0;
  xbar_pkg::src_id_t [1:0] m_src = '0;
  xbar_pkg::word_t   [1:0] m_data = '0;
  logic              [1:0] m_v = '0;
  logic              [1:0] m_ready = '0;
  logic              [1:0] pend = '0;
  logic              [1:0] shown = '0;
  int                      delay [2] = '{default: 0};
  xbar_pkg::word_t         dest_mem [xbar_pkg::paddr_t];

  // Scoreboard of the one request each requester has in flight
  xbar_pkg::mem_op_e       exp_op [num_req_lp];
  xbar_pkg::paddr_t        exp_addr [num_req_lp];
  xbar_pkg::word_t         exp_wdata [num_req_lp];
  xbar_pkg::word_t         exp_data [num_req_lp];
  int                      exp_kind [num_req_lp];
  int                      issued [num_req_lp] = '{default: 0};
  logic [num_req_lp-1:0]   outstanding = '0;
  logic [num_req_lp-1:0]   sent = '0;
  xbar_pkg::word_t         exp_mem [xbar_pkg::paddr_t];
  int                      cycles = 0;
  int                      completed = 0;

  unicore_mem_xbar dut
    (.clk_i(clk_i), .arst_n_i(arst_n_i)
     ,.req_cmd_op_i(req_cmd_op), .req_cmd_addr_i(req_cmd_addr)
     ,.req_cmd_src_i(req_cmd_src), .req_cmd_data_i(req_cmd_data)
     ,.req_cmd_v_i(req_cmd_v), .req_cmd_ready_o(req_cmd_ready)
     ,.req_resp_op_o(req_resp_op), .req_resp_addr_o(req_resp_addr)
     ,.req_resp_src_o(req_resp_src), .req_resp_data_o(req_resp_data)
     ,.req_resp_v_o(req_resp_v), .req_resp_yumi_i(resp_yumi)
     ,.dram_cmd_op_o(dram_cmd_op), .dram_cmd_addr_o(dram_cmd_addr)
     ,.dram_cmd_src_o(dram_cmd_src), .dram_cmd_data_o(dram_cmd_data)
     ,.dram_cmd_v_o(dram_cmd_v), .dram_cmd_ready_i(m_ready[0])
     ,.dram_resp_op_i(m_op[0]), .dram_resp_addr_i(m_addr[0]), .dram_resp_src_i(m_src[0])
     ,.dram_resp_data_i(m_data[0]), .dram_resp_v_i(m_v[0]), .dram_resp_yumi_o(dram_resp_yumi)
     ,.io_cmd_op_o(io_cmd_op), .io_cmd_addr_o(io_cmd_addr)
     ,.io_cmd_src_o(io_cmd_src), .io_cmd_data_o(io_cmd_data)
     ,.io_cmd_v_o(io_cmd_v), .io_cmd_ready_i(m_ready[1])
     ,.io_resp_op_i(m_op[1]), .io_resp_addr_i(m_addr[1]), .io_resp_src_i(m_src[1])
     ,.io_resp_data_i(m_data[1]), .io_resp_v_i(m_v[1]), .io_resp_yumi_o(io_resp_yumi)
     );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_addr(input xbar_pkg::paddr_t got, input xbar_pkg::paddr_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_data(input xbar_pkg::word_t got, input xbar_pkg::word_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_op(input xbar_pkg::mem_op_e got, input xbar_pkg::mem_op_e exp,
                          input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: %s got %s, expected %s", $time, what,
                          got.name(), exp.name()));
  endtask

  task automatic check_src(input xbar_pkg::src_id_t got, input xbar_pkg::src_id_t exp,
                           input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: %s got %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic issue_request(input int r);
    int kind;
    int off;
    int dev;
    xbar_pkg::paddr_t  addr;
    xbar_pkg::mem_op_e op;
    xbar_pkg::word_t   wdata;
    kind = $urandom % 3;
    // Each requester owns a 4 KB window, few words so reads hit earlier writes
    off  = r * 4096 + int'($urandom % 16) * 8;
    dev  = $urandom % 16;
    if (dev == int'(`XBAR_IO_DEV))
      dev = 0;
    if (kind == kind_dram_lp)
      addr = xbar_pkg::paddr_t'(`XBAR_DRAM_BASE) + xbar_pkg::paddr_t'(off);
    else if (kind == kind_io_lp)
      addr = xbar_pkg::paddr_t'((int'(`XBAR_IO_DEV) << `XBAR_DEV_LSB) + off);
    else
      addr = xbar_pkg::paddr_t'((dev << `XBAR_DEV_LSB) + off);
    op    = (($urandom % 2) != 0) ? xbar_pkg::e_mem_wr : xbar_pkg::e_mem_rd;
    wdata = {$urandom, $urandom};
    if (op == xbar_pkg::e_mem_wr)
    begin
      if (kind != kind_lb_lp)
        exp_mem[addr] = wdata;
      exp_data[r] = '0;
    end
    else if (kind == kind_lb_lp)
      exp_data[r] = '0;
    else if (exp_mem.exists(addr))
      exp_data[r] = exp_mem[addr];
    else
      exp_data[r] = xbar_pkg::word_t'(addr);
    exp_op[r]    = op;
    exp_addr[r]  = addr;
    exp_wdata[r] = wdata;
    exp_kind[r]  = kind;
    outstanding[r] = 1'b1;
    issued[r]++;
    req_cmd_op[r]   <= op;
    req_cmd_addr[r] <= addr;
    req_cmd_src[r]  <= xbar_pkg::src_id_t'(r);
    req_cmd_data[r] <= wdata;
    req_cmd_v[r]    <= 1'b1;
  endtask

  task automatic accept_command(input int m, input xbar_pkg::mem_op_e op,
                                input xbar_pkg::paddr_t addr, input xbar_pkg::src_id_t src,
                                input xbar_pkg::word_t data);
    int s;
    s = int'(src);
    if (pend[m])
      abort_run($sformatf("Port %0d sent a command while its responder was busy", m));
    if (s >= num_req_lp || !outstanding[s] || sent[s])
      abort_run($sformatf("Port %0d sent a command for src %0d with no open request", m, s));
    if (m == kind_dram_lp && addr < xbar_pkg::paddr_t'(`XBAR_DRAM_BASE))
      abort_run($sformatf("DRAM port got the local address %h", addr));
    if (m == kind_io_lp && (addr >= xbar_pkg::paddr_t'(`XBAR_DRAM_BASE) ||
        addr[`XBAR_DEV_LSB +: 4] != xbar_pkg::dev_id_t'(`XBAR_IO_DEV)))
      abort_run($sformatf("I/O port got the non-I/O address %h", addr));
    if (exp_kind[s] != m)
      abort_run($sformatf("Request of requester %0d went out on the wrong port", s));
    check_op(op, exp_op[s], "command op");
    check_addr(addr, exp_addr[s], "command addr");
    if (op == xbar_pkg::e_mem_wr)
    begin
      check_data(data, exp_wdata[s], "command write data");
      dest_mem[addr] = data;
      m_data[m] <= '0;
    end
    else if (dest_mem.exists(addr))
      m_data[m] <= dest_mem[addr];
    else
      m_data[m] <= xbar_pkg::word_t'(addr);
    m_op[m]   <= op;
    m_addr[m] <= addr;
    m_src[m]  <= src;
    sent[s]  = 1'b1;
    pend[m]  = 1'b1;
    delay[m] = $urandom % 6;
  endtask

  task automatic check_response(input int r);
    if (!outstanding[r])
      abort_run($sformatf("Channel %0d returned a response with no open request", r));
    check_src(req_resp_src[r], xbar_pkg::src_id_t'(r), "response src");
    check_op(req_resp_op[r], exp_op[r], "response op");
    check_addr(req_resp_addr[r], exp_addr[r], "response addr");
    check_data(req_resp_data[r], exp_data[r], "response data");
    outstanding[r] = 1'b0;
    sent[r] = 1'b0;
    completed++;
  endtask

  always @(posedge clk_i)
  begin : step
    logic yumi;
    if (arst_n_i)
    begin
      cycles++;
      for (int m = 0; m < 2; m++)
      begin
        yumi = (m == 0) ? dram_resp_yumi : io_resp_yumi;
        if (shown[m] && yumi)
        begin
          pend[m]  = 1'b0;
          shown[m] = 1'b0;
          m_v[m]  <= 1'b0;
        end
        if (m == 0 && dram_cmd_v)
          accept_command(m, dram_cmd_op, dram_cmd_addr, dram_cmd_src, dram_cmd_data);
        else if (m == 1 && io_cmd_v)
          accept_command(m, io_cmd_op, io_cmd_addr, io_cmd_src, io_cmd_data);
        else if (pend[m] && !shown[m])
        begin
          if (delay[m] == 0)
          begin
            shown[m] = 1'b1;
            m_v[m]  <= 1'b1;
          end
          else
            delay[m]--;
        end
        m_ready[m] <= !pend[m] && (($urandom % 4) != 0);
      end
      for (int r = 0; r < num_req_lp; r++)
      begin
        // yumi drops after each take, so it never meets an empty FIFO
        if (resp_yumi[r] && req_resp_v[r])
        begin
          check_response(r);
          resp_yumi[r] <= 1'b0;
        end
        else
          resp_yumi[r] <= req_resp_v[r] && (($urandom % 2) != 0);
        if (req_cmd_v[r] && req_cmd_ready[r])
          req_cmd_v[r] <= 1'b0;
        else if (!req_cmd_v[r] && !outstanding[r] && issued[r] < reqs_per_lp &&
                 (($urandom % 2) != 0))
          issue_request(r);
      end
    end
  end

  initial
  begin
    void'($urandom(32'he7d57a31));
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Counters settle on the rising edge, so look at them half a cycle later
    while (completed < total_lp && cycles < timeout_lp)
      @(negedge clk_i);
    if (completed == total_lp)
    begin
      $display("test passed");
      $finish;
    end
    else
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d requests completed",
                          cycles, completed, total_lp));
  end

endmodule

`default_nettype wire

// File: unicore_mem_xbar.f
+incdir+hw
hw/xbar_pkg.sv
hw/two_entry_fifo.sv
hw/loopback_responder.sv
hw/cmd_router.sv
hw/resp_router.sv
hw/unicore_mem_xbar.sv
bench/unicore_mem_xbar_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module unicore_mem_xbar_tb \
  -f unicore_mem_xbar.f -o unicore_mem_xbar_sim || { echo "build failed"; exit 1; }
./obj_dir/unicore_mem_xbar_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && { echo "simulation reported an error"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation clean"
